/* dv/decode_checks.svh */
`ifndef DECODE_CHECKS_SVH
`define DECODE_CHECKS_SVH

function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

task automatic stop_on_error(input string why);
    $display("*** TEST FAILED ***");
    $fatal(1, "%s", why);
endtask

task automatic check_alu(input string name, input alu_op_t got, input alu_op_t exp);
    if (got !== exp) begin
        $display("[FAIL] time %0t %s: got %s expected %s", $time, name, got.name(), exp.name());
        stop_on_error($sformatf("%s does not match", name));
    end
endtask

task automatic check_src1(input string name, input src1_sel_t got, input src1_sel_t exp);
    if (got !== exp) begin
        $display("[FAIL] time %0t %s: got %s expected %s", $time, name, got.name(), exp.name());
        stop_on_error($sformatf("%s does not match", name));
    end
endtask

task automatic check_src2(input string name, input src2_sel_t got, input src2_sel_t exp);
    if (got !== exp) begin
        $display("[FAIL] time %0t %s: got %s expected %s", $time, name, got.name(), exp.name());
        stop_on_error($sformatf("%s does not match", name));
    end
endtask

task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("[FAIL] time %0t %s: got %h expected %h", $time, name, got, exp);
        stop_on_error($sformatf("%s does not match", name));
    end
endtask

task automatic check_index(input string name, input logic [4:0] got, input logic [4:0] exp);
    if (got !== exp) begin
        $display("[FAIL] time %0t %s: got %0d expected %0d", $time, name, got, exp);
        stop_on_error($sformatf("%s does not match", name));
    end
endtask

task automatic check_funct(input string name, input logic [2:0] got, input logic [2:0] exp);
    if (got !== exp) begin
        $display("[FAIL] time %0t %s: got %b expected %b", $time, name, got, exp);
        stop_on_error($sformatf("%s does not match", name));
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("[FAIL] time %0t %s: got %b expected %b", $time, name, got, exp);
        stop_on_error($sformatf("%s does not match", name));
    end
endtask

`endif

/* dv/decode_stage_tb.sv */
`default_nettype none

`include "rv_consts.svh"

module decode_stage_tb import rv_pkg::*; ();

    typedef struct {
        logic [`XLEN-1:0] inst;
        logic [`XLEN-1:0] pc;
        logic [1:0]       flush;            // 1 flushes the transfer and 2 flushes while idle.
        logic             ready;            // Low means back-pressure before the transfer.
        alu_op_t          alu;
        src1_sel_t        s1;
        src2_sel_t        s2;
        logic [7:0]       flags;            // ren wen br inv jump rwen ecall mret.
        logic [`XLEN-1:0] imm;
        logic [4:0]       rd;
        logic [2:0]       f3;
    } entry_t;

    localparam int NUM = 23;

    logic clock = 1'b0;
    logic reset, inst_valid, flush, out_ready, wb_wen;
    logic [`XLEN-1:0] inst, pc, wb_data;
    logic [`REG_ADDR_W-1:0] wb_rd;
    logic inst_ready, out_valid;
    logic [`XLEN-1:0] pc_out, imm, rs1_value, rs2_value;
    logic [4:0] rd;
    logic [2:0] funct3;
    alu_op_t alu_op;
    src1_sel_t src1_sel;
    src2_sel_t src2_sel;
    logic mem_ren, mem_wen, branch, branch_inv, jump, reg_wen, ecall, mret;

    logic [`XLEN-1:0] model [`REG_COUNT];   // Expected register contents.
    logic [31:0] rnd;

    entry_t tbl [NUM] = '{
        '{32'h002081b3, 32'h100, 2'd0, 1'b1, alu_add, src1_reg, src2_reg, 8'h04, 32'h0, 5'd3, 3'd0},
        '{32'h407302b3, 32'h104, 2'd0, 1'b1, alu_sub, src1_reg, src2_reg, 8'h04, 32'h20, 5'd5, 3'd0},
        '{32'h40945233, 32'h108, 2'd0, 1'b1, alu_sra, src1_reg, src2_reg, 8'h04, 32'h20, 5'd4, 3'd5},
        '{32'h00053133, 32'h10c, 2'd0, 1'b1, alu_sltu, src1_reg, src2_reg, 8'h04, 32'h0, 5'd2, 3'd3},
        '{32'hffb10093, 32'h110, 2'd0, 1'b1, alu_add, src1_reg, src2_imm, 8'h04, 32'hfffffffb,
          5'd1, 3'd0},
        '{32'h06422193, 32'h114, 2'd0, 1'b1, alu_slt, src1_reg, src2_imm, 8'h04, 32'h64, 5'd3, 3'd2},
        '{32'h4033d313, 32'h118, 2'd0, 1'b1, alu_sra, src1_reg, src2_imm, 8'h04, 32'h403, 5'd6, 3'd5},
        '{32'h0081a283, 32'h11c, 2'd0, 1'b0, alu_add, src1_reg, src2_imm, 8'h84, 32'h8, 5'd5, 3'd2},
        '{32'hfe612a23, 32'h120, 2'd0, 1'b1, alu_add, src1_reg, src2_imm, 8'h40, 32'hfffffff4,
          5'd20, 3'd2},
        '{32'h123453b7, 32'h124, 2'd0, 1'b1, alu_add, src1_zero, src2_imm, 8'h04, 32'h12345000,
          5'd7, 3'd5},
        '{32'hfffff417, 32'h128, 2'd0, 1'b1, alu_add, src1_pc, src2_imm, 8'h04, 32'hfffff000,
          5'd8, 3'd7},
        '{32'hffdff0ef, 32'h12c, 2'd0, 1'b1, alu_add, src1_pc, src2_imm, 8'h0c, 32'hfffffffc,
          5'd1, 3'd7},
        '{32'h00008067, 32'h130, 2'd0, 1'b1, alu_add, src1_reg, src2_imm, 8'h0c, 32'h0, 5'd0, 3'd0},
        '{32'h00208863, 32'h134, 2'd0, 1'b1, alu_eq, src1_reg, src2_reg, 8'h30, 32'h10, 5'd16, 3'd0},
        '{32'hfe419ce3, 32'h138, 2'd0, 1'b1, alu_eq, src1_reg, src2_reg, 8'h20, 32'hfffffff8,
          5'd25, 3'd1},
        '{32'h0062c0e3, 32'h13c, 2'd0, 1'b1, alu_slt, src1_reg, src2_reg, 8'h20, 32'h800, 5'd1, 3'd4},
        '{32'h0083d263, 32'h140, 2'd0, 1'b1, alu_slt, src1_reg, src2_reg, 8'h30, 32'h4, 5'd4, 3'd5},
        '{32'h7ea4efe3, 32'h144, 2'd0, 1'b1, alu_sltu, src1_reg, src2_reg, 8'h20, 32'hffe,
          5'd31, 3'd6},
        '{32'h80c5f063, 32'h148, 2'd0, 1'b1, alu_sltu, src1_reg, src2_reg, 8'h30, 32'hfffff000,
          5'd0, 3'd7},
        '{32'h002081b3, 32'h14c, 2'd1, 1'b1, alu_add, src1_reg, src2_imm, 8'h00, 32'h0, 5'd0, 3'd0},
        '{32'h00000073, 32'h150, 2'd0, 1'b1, alu_add, src1_reg, src2_imm, 8'h06, 32'h0, 5'd0, 3'd0},
        '{32'h407302b3, 32'h154, 2'd2, 1'b1, alu_add, src1_reg, src2_imm, 8'h00, 32'h0, 5'd0, 3'd0},
        '{32'h30200073, 32'h158, 2'd0, 1'b0, alu_add, src1_reg, src2_imm, 8'h05, 32'h302, 5'd0, 3'd0}
    };

    `include "decode_checks.svh"

    decode_stage u_dut (.*);

    always #50 clock = ~clock;

    task automatic write_reg(input logic [`REG_ADDR_W-1:0] idx);
        rnd = xorshift(rnd);
        @(posedge clock);
        wb_wen  <= 1'b1;
        wb_rd   <= idx;
        wb_data <= rnd;
        if (idx != '0) begin
            model[idx] = rnd;               // x0 keeps zero.
        end
    endtask

    task automatic apply_entry(input entry_t e);
        logic [`XLEN-1:0] dec;
        dec = (e.flush == 2'd0) ? e.inst : '0;   // A bubble decodes the zero word.
        write_reg(e.inst[18:15]);
        write_reg(e.inst[23:20]);
        @(posedge clock);
        wb_wen <= 1'b0;
        flush  <= (e.flush == 2'd2);
        if (!e.ready) begin
            @(posedge clock);
            out_ready  <= 1'b0;
            inst_valid <= 1'b1;
            inst       <= e.inst;
            pc         <= e.pc;
            repeat (3) begin
                @(negedge clock);
                check_flag("inst_ready", inst_ready, 1'b0);
                check_flag("out_valid", out_valid, 1'b0);
            end
        end
        @(posedge clock);
        out_ready  <= 1'b1;
        inst_valid <= 1'b1;
        inst       <= e.inst;
        pc         <= e.pc;
        flush      <= (e.flush == 2'd1);
        @(negedge clock);
        while (!inst_ready) begin
            @(negedge clock);
        end
        @(posedge clock);
        inst_valid <= 1'b0;
        flush      <= 1'b0;
        @(negedge clock);
        check_flag("out_valid", out_valid, e.flush == 2'd0);
        check_word("pc_out", pc_out, e.pc);
        check_index("rd", rd, e.rd);
        check_funct("funct3", funct3, e.f3);
        check_alu("alu_op", alu_op, e.alu);
        check_src1("src1_sel", src1_sel, e.s1);
        check_src2("src2_sel", src2_sel, e.s2);
        check_flag("mem_ren", mem_ren, e.flags[7]);
        check_flag("mem_wen", mem_wen, e.flags[6]);
        check_flag("branch", branch, e.flags[5]);
        check_flag("branch_inv", branch_inv, e.flags[4]);
        check_flag("jump", jump, e.flags[3]);
        check_flag("reg_wen", reg_wen, e.flags[2]);
        check_flag("ecall", ecall, e.flags[1]);
        check_flag("mret", mret, e.flags[0]);
        check_word("imm", imm, e.imm);
        check_word("rs1_value", rs1_value, model[dec[18:15]]);
        check_word("rs2_value", rs2_value, model[dec[23:20]]);
        @(negedge clock);
        check_flag("out_valid", out_valid, 1'b0);   // Single cycle pulse.
    endtask

    initial begin
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        pc         = '0;
        flush      = 1'b0;
        out_ready  = 1'b1;
        wb_wen     = 1'b0;
        wb_rd      = '0;
        wb_data    = '0;
        rnd        = 32'h83b2;
        for (int i = 0; i < `REG_COUNT; i++) begin
            model[i] = '0;
        end
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        for (int n = 0; n < NUM; n++) begin
            apply_entry(tbl[n]);
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

    // Watchdog.
    initial begin
        repeat (NUM * 20 + 50) @(posedge clock);
        stop_on_error("watchdog expired before the stimulus table was done");
    end

endmodule

`default_nettype wire

/* logic/ctrl_decode.sv */
`default_nettype none

`include "rv_consts.svh"

module ctrl_decode import rv_pkg::*; (
    input  logic [`XLEN-1:0]  inst_q,
    output opcode_t           opcode,
    output logic [2:0]        funct3,
    output logic [4:0]        rs1,
    output logic [4:0]        rs2,
    output logic [4:0]        rd,
    output alu_op_t           alu_op,
    output src1_sel_t         src1_sel,
    output src2_sel_t         src2_sel,
    output logic              mem_ren,
    output logic              mem_wen,
    output logic              branch,
    output logic              branch_inv,
    output logic              jump,
    output logic              reg_wen,
    output logic              ecall,
    output logic              mret
);

    logic [6:0] funct7;

    assign opcode = opcode_t'(inst_q[`OPCODE_MSB:`OPCODE_LSB]);
    assign funct3 = inst_q[`FUNCT3_MSB:`FUNCT3_LSB];
    assign funct7 = inst_q[`FUNCT7_MSB:`FUNCT7_LSB];
    assign rs1    = inst_q[`RS1_MSB:`RS1_LSB];
    assign rs2    = inst_q[`RS2_MSB:`RS2_LSB];
    assign rd     = inst_q[`RD_MSB:`RD_LSB];

    assign mem_ren = (opcode == op_load);
    assign mem_wen = (opcode == op_store);
    assign branch  = (opcode == op_branch);
    assign jump    = (opcode == op_jal) || (opcode == op_jalr);

    // beq, bge and bgeu take the inverted compare result.
    assign branch_inv = branch &&
                        (funct3 == 3'b000 || funct3 == 3'b101 || funct3 == 3'b111);

    assign reg_wen = !(opcode == op_store || opcode == op_branch || inst_q == '0);

    assign ecall = (inst_q == `INST_ECALL);
    assign mret  = (inst_q == `INST_MRET);

    always_comb begin
        case (opcode)
            op_lui:             src1_sel = src1_zero;
            op_auipc, op_jal:   src1_sel = src1_pc;
            default:            src1_sel = src1_reg;
        endcase
    end

    assign src2_sel = (opcode == op_reg || opcode == op_branch) ? src2_reg : src2_imm;

    always_comb begin
        alu_op = alu_add;                       // Address and pc arithmetic.
        case (opcode)
            op_reg, op_imm: begin
                case (funct3)
                    3'b000: begin
                        if (opcode == op_reg && funct7[5]) begin
                            alu_op = alu_sub;
                        end else begin
                            alu_op = alu_add;
                        end
                    end
                    3'b001:  alu_op = alu_sll;
                    3'b010:  alu_op = alu_slt;
                    3'b011:  alu_op = alu_sltu;
                    3'b100:  alu_op = alu_xor;
                    3'b101:  alu_op = funct7[5] ? alu_sra : alu_srl;
                    3'b110:  alu_op = alu_or;
                    default: alu_op = alu_and;
                endcase
            end
            op_branch: begin
                case (funct3)
                    3'b000, 3'b001: alu_op = alu_eq;
                    3'b100, 3'b101: alu_op = alu_slt;
                    3'b110, 3'b111: alu_op = alu_sltu;
                    default:        alu_op = alu_add;
                endcase
            end
            default: alu_op = alu_add;
        endcase
    end

endmodule

`default_nettype wire

/* logic/decode_stage.sv */
`default_nettype none

`include "rv_consts.svh"

module decode_stage import rv_pkg::*; (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   inst_valid,
    input  logic [`XLEN-1:0]       inst,
    input  logic [`XLEN-1:0]       pc,
    input  logic                   flush,
    output logic                   inst_ready,
    input  logic                   out_ready,
    output logic                   out_valid,
    output logic [`XLEN-1:0]       pc_out,
    output logic [4:0]             rd,
    output logic [2:0]             funct3,
    output logic [`XLEN-1:0]       imm,
    output logic [`XLEN-1:0]       rs1_value,
    output logic [`XLEN-1:0]       rs2_value,
    output alu_op_t                alu_op,
    output src1_sel_t              src1_sel,
    output src2_sel_t              src2_sel,
    output logic                   mem_ren,
    output logic                   mem_wen,
    output logic                   branch,
    output logic                   branch_inv,
    output logic                   jump,
    output logic                   reg_wen,
    output logic                   ecall,
    output logic                   mret,
    input  logic                   wb_wen,
    input  logic [`REG_ADDR_W-1:0] wb_rd,
    input  logic [`XLEN-1:0]       wb_data
);

    logic [`XLEN-1:0] inst_q;
    opcode_t          opcode;
    logic [4:0]       rs1;
    logic [4:0]       rs2;

    inst_latch u_inst_latch (
        .clock      (clock),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .pc         (pc),
        .flush      (flush),
        .out_ready  (out_ready),
        .inst_ready (inst_ready),
        .out_valid  (out_valid),
        .inst_q     (inst_q),
        .pc_q       (pc_out)
    );

    ctrl_decode u_ctrl_decode (
        .inst_q     (inst_q),
        .opcode     (opcode),
        .funct3     (funct3),
        .rs1        (rs1),
        .rs2        (rs2),
        .rd         (rd),
        .alu_op     (alu_op),
        .src1_sel   (src1_sel),
        .src2_sel   (src2_sel),
        .mem_ren    (mem_ren),
        .mem_wen    (mem_wen),
        .branch     (branch),
        .branch_inv (branch_inv),
        .jump       (jump),
        .reg_wen    (reg_wen),
        .ecall      (ecall),
        .mret       (mret)
    );

    imm_gen u_imm_gen (
        .inst_q (inst_q),
        .opcode (opcode),
        .imm    (imm)
    );

    // RV32E has 16 registers so the upper index bit is dropped.
    reg_file u_reg_file (
        .clock     (clock),
        .reset     (reset),
        .rs1_addr  (rs1[`REG_ADDR_W-1:0]),
        .rs2_addr  (rs2[`REG_ADDR_W-1:0]),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .wb_wen    (wb_wen),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

endmodule

`default_nettype wire

/* logic/imm_gen.sv */
`default_nettype none

`include "rv_consts.svh"

module imm_gen import rv_pkg::*; (
    input  logic [`XLEN-1:0]  inst_q,
    input  opcode_t           opcode,
    output logic [`XLEN-1:0]  imm
);

    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;
    logic [`XLEN-1:0] imm_r;

    assign imm_i = {{(`XLEN-12){inst_q[31]}}, inst_q[31:20]};
    assign imm_s = {{(`XLEN-12){inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
    assign imm_b = {{(`XLEN-13){inst_q[31]}}, inst_q[31], inst_q[7],
                    inst_q[30:25], inst_q[11:8], 1'b0};
    assign imm_u = {inst_q[31:12], 12'b0};
    assign imm_j = {{(`XLEN-21){inst_q[31]}}, inst_q[31], inst_q[19:12],
                    inst_q[20], inst_q[30:21], 1'b0};
    assign imm_r = {{(`XLEN-7){1'b0}}, inst_q[31:25]};   // Zero-extended funct7.

    always_comb begin
        case (opcode)
            op_reg:                                  imm = imm_r;
            op_load, op_imm, op_jalr, op_system:     imm = imm_i;
            op_store:                                imm = imm_s;
            op_branch:                               imm = imm_b;
            op_lui, op_auipc:                        imm = imm_u;
            op_jal:                                  imm = imm_j;
            default:                                 imm = '0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/inst_latch.sv */
`default_nettype none

`include "rv_consts.svh"

module inst_latch (
    input  logic              clock,
    input  logic              reset,
    input  logic              inst_valid,
    input  logic [`XLEN-1:0]  inst,
    input  logic [`XLEN-1:0]  pc,
    input  logic              flush,
    input  logic              out_ready,
    output logic              inst_ready,
    output logic              out_valid,
    output logic [`XLEN-1:0]  inst_q,
    output logic [`XLEN-1:0]  pc_q
);

    logic xfer;
    logic flush_pending;
    logic bubble;

    assign inst_ready = out_ready;              // Stall straight through to fetch.
    assign xfer       = inst_valid & inst_ready;
    assign bubble     = flush | flush_pending;

    // Flush seen while idle waits for the next transfer.
    always_ff @(posedge clock) begin
        if (reset) begin
            flush_pending <= 1'b0;
        end else if (xfer) begin
            flush_pending <= 1'b0;
        end else if (flush) begin
            flush_pending <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= xfer & ~bubble;        // One cycle pulse per real instruction.
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            inst_q <= '0;
            pc_q   <= '0;
        end else if (xfer) begin
            inst_q <= bubble ? '0 : inst;       // Bubble decodes as a no-op.
            pc_q   <= pc;
        end
    end

endmodule

`default_nettype wire

/* logic/reg_file.sv */
`default_nettype none

`include "rv_consts.svh"

module reg_file (
    input  logic                   clock,
    input  logic                   reset,
    input  logic [`REG_ADDR_W-1:0] rs1_addr,
    input  logic [`REG_ADDR_W-1:0] rs2_addr,
    output logic [`XLEN-1:0]       rs1_value,
    output logic [`XLEN-1:0]       rs2_value,
    input  logic                   wb_wen,
    input  logic [`REG_ADDR_W-1:0] wb_rd,
    input  logic [`XLEN-1:0]       wb_data
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_wen && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;             // x0 stays zero.
        end
    end

    // Without a write bypass a write shows up one cycle later.
    assign rs1_value = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_value = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

/* logic/rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define XLEN 32
`define REG_COUNT 16
`define REG_ADDR_W 4

// Instruction field positions.
`define OPCODE_MSB 6
`define OPCODE_LSB 0
`define RD_MSB 11
`define RD_LSB 7
`define FUNCT3_MSB 14
`define FUNCT3_LSB 12
`define RS1_MSB 19
`define RS1_LSB 15
`define RS2_MSB 24
`define RS2_LSB 20
`define FUNCT7_MSB 31
`define FUNCT7_LSB 25

`define INST_ECALL 32'h0000_0073
`define INST_MRET 32'h3020_0073

`endif

/* logic/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    // RV32 major opcodes.
    typedef enum logic [6:0] {
        op_load   = 7'b000_0011,
        op_imm    = 7'b001_0011,
        op_auipc  = 7'b001_0111,
        op_store  = 7'b010_0011,
        op_reg    = 7'b011_0011,
        op_lui    = 7'b011_0111,
        op_branch = 7'b110_0011,
        op_jalr   = 7'b110_0111,
        op_jal    = 7'b110_1111,
        op_system = 7'b111_0011
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_slt  = 4'd2,
        alu_sltu = 4'd3,
        alu_xor  = 4'd4,
        alu_or   = 4'd5,
        alu_and  = 4'd6,
        alu_sll  = 4'd7,
        alu_srl  = 4'd8,
        alu_sra  = 4'd9,
        alu_eq   = 4'd10                  // Equality compare for beq and bne.
    } alu_op_t;

    typedef enum logic [1:0] {
        src1_reg  = 2'd0,
        src1_pc   = 2'd1,
        src1_zero = 2'd2
    } src1_sel_t;

    typedef enum logic {
        src2_reg = 1'b0,
        src2_imm = 1'b1
    } src2_sel_t;

endpackage

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build the decode stage testbench with Verilator, run it and look for the pass line.
cd "$(dirname "$0")" &&
verilator --binary -f vlog.f --top-module decode_stage_tb -o decode_stage_sim &&
./obj_dir/decode_stage_sim | grep -F "*** TEST PASSED ***" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* vlog.f */
+incdir+logic
+incdir+dv
logic/rv_pkg.sv
logic/inst_latch.sv
logic/ctrl_decode.sv
logic/imm_gen.sv
logic/reg_file.sv
logic/decode_stage.sv
dv/decode_stage_tb.sv
